// ==== hw/z80_settings.svh ====
// Fixed core parameters shared by the package and the RTL blocks
// Include wherever a bus width or the reset vector is needed
`ifndef Z80_SETTINGS_SVH
`define Z80_SETTINGS_SVH

// Program counter value after reset
`define Z80_RESET_PC 16'h0000

// Data bus width in bits
`define Z80_DW 8

// Address bus width in bits
`define Z80_AW 16

`endif

// ==== hw/z80_pkg.sv ====
// Shared types of the cut-down Z80 core
// Bus structs, flag struct and the enums for states, opcodes and control
`default_nettype none

`include "z80_settings.svh"

package z80_pkg;

    // Wishbone master to slave
    typedef struct packed {
        logic               cyc;
        logic               stb;
        logic               we;
        logic [`Z80_AW-1:0] adr;
        logic [`Z80_DW-1:0] dat;
    } wb_m2s_t;

    // Wishbone slave to master
    typedef struct packed {
        logic               ack;
        logic [`Z80_DW-1:0] dat;
    } wb_s2m_t;

    // One transfer requested by the sequencer
    typedef struct packed {
        logic               valid;
        logic               we;
        logic [`Z80_AW-1:0] adr;
        logic [`Z80_DW-1:0] wdata;
    } bus_req_t;

    // Only sign, zero and carry are kept
    typedef struct packed {
        logic s;
        logic z;
        logic c;
    } flags_t;

    // First eight follow opcode bits 5..3 of the ALU group
    typedef enum logic [3:0] {
        ALU_ADD, ALU_ADC, ALU_SUB, ALU_SBC,
        ALU_AND, ALU_XOR, ALU_OR,  ALU_CP,
        ALU_INC, ALU_DEC, ALU_PASS
    } alu_op_t;

    typedef enum logic [1:0] {PC_HOLD, PC_INC, PC_LOAD} pc_op_t;

    typedef enum logic [2:0] {
        ST_FETCH, ST_DECODE, ST_OPER_LO, ST_OPER_HI, ST_MEM, ST_EXEC, ST_HALTED
    } cpu_state_t;

    // Fixed opcodes; the register forms are decoded from their fields
    typedef enum logic [7:0] {
        OP_LD_NN_A = 8'h32,
        OP_LD_A_NN = 8'h3A,
        OP_JP_NZ   = 8'hC2,
        OP_JP_NN   = 8'hC3,
        OP_JP_Z    = 8'hCA,
        OP_HALT    = 8'h76
    } opcode_t;

endpackage

`default_nettype wire

// ==== hw/reg_file.sv ====
// General registers B, C, D, E, H, L and A by their Z80 codes
// Two combinational read ports and one synchronous write port
`timescale 1ns/1ps
`default_nettype none

`include "z80_settings.svh"

module reg_file (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [2:0]         rd_sel_a,
    input  logic [2:0]         rd_sel_b,
    output logic [`Z80_DW-1:0] rd_a,
    output logic [`Z80_DW-1:0] rd_b,
    input  logic               wr_en,
    input  logic [2:0]         wr_sel,
    input  logic [`Z80_DW-1:0] wr_data
);

    // Code 6 is (HL) and has no storage
    localparam logic [2:0] REG_HL = 3'd6;

    logic [`Z80_DW-1:0] regs [0:7];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_sel != REG_HL) begin
            regs[wr_sel] <= wr_data;
        end
    end

    // Read ports
    assign rd_a = (rd_sel_a == REG_HL) ? '0 : regs[rd_sel_a];
    assign rd_b = (rd_sel_b == REG_HL) ? '0 : regs[rd_sel_b];

endmodule

`default_nettype wire

// ==== hw/alu.sv ====
// 8-bit ALU for the A,r group and INC/DEC
// Result is combinational; S, Z and C are registered on flag_we
`timescale 1ns/1ps
`default_nettype none

`include "z80_settings.svh"

module alu
    import z80_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  alu_op_t            alu_op,
    input  logic [`Z80_DW-1:0] alu_a,
    input  logic [`Z80_DW-1:0] alu_b,
    input  logic               flag_we,
    output logic [`Z80_DW-1:0] alu_y,
    output flags_t             flags
);

    logic [`Z80_DW-1:0] res;
    logic               carry;
    logic [`Z80_DW:0]   cin;

    // Stored carry widened for ADC and SBC
    assign cin = {{`Z80_DW{1'b0}}, flags.c};

    always_comb begin
        // Carry holds unless the op says otherwise
        carry = flags.c;
        res   = alu_a;
        case (alu_op)
            ALU_ADD: {carry, res} = {1'b0, alu_a} + {1'b0, alu_b};
            ALU_ADC: {carry, res} = {1'b0, alu_a} + {1'b0, alu_b} + cin;
            // Bit 8 of the difference is the borrow
            ALU_SUB, ALU_CP: {carry, res} = {1'b0, alu_a} - {1'b0, alu_b};
            ALU_SBC: {carry, res} = {1'b0, alu_a} - {1'b0, alu_b} - cin;
            ALU_AND: begin
                res   = alu_a & alu_b;
                carry = 1'b0;
            end
            ALU_XOR: begin
                res   = alu_a ^ alu_b;
                carry = 1'b0;
            end
            ALU_OR: begin
                res   = alu_a | alu_b;
                carry = 1'b0;
            end
            // INC and DEC leave C alone
            ALU_INC: res = alu_a + 8'd1;
            ALU_DEC: res = alu_a - 8'd1;
            default: res = alu_a;
        endcase
    end

    assign alu_y = res;

    // Flag register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flags <= '0;
        end else if (flag_we) begin
            flags.s <= res[`Z80_DW-1];
            flags.z <= (res == '0);
            flags.c <= carry;
        end
    end

endmodule

`default_nettype wire

// ==== hw/address_latch.sv ====
// Program counter with incrementer and jump load
// Also the two-byte operand address latch, the WZ pair of a real Z80
`timescale 1ns/1ps
`default_nettype none

`include "z80_settings.svh"

module address_latch
    import z80_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  pc_op_t             pc_op,
    input  logic               cap_lo,
    input  logic               cap_hi,
    input  logic [`Z80_DW-1:0] rdata,
    output logic [`Z80_AW-1:0] pc,
    output logic [`Z80_AW-1:0] oper_addr
);

    // Program counter, wraps at the top of memory
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= `Z80_RESET_PC;
        end else begin
            case (pc_op)
                PC_INC:  pc <= pc + 16'd1;
                PC_LOAD: pc <= oper_addr;
                default: pc <= pc;
            endcase
        end
    end

    // Operand bytes come in little endian order
    always_ff @(posedge clk) begin
        if (cap_lo) begin
            oper_addr[7:0] <= rdata;
        end
        if (cap_hi) begin
            oper_addr[15:8] <= rdata;
        end
    end

endmodule

`default_nettype wire

// ==== hw/bus_control.sv ====
// Wishbone classic master doing one transfer per sequencer request
// Captures read data on ack and pulses bus_done one cycle later
`timescale 1ns/1ps
`default_nettype none

`include "z80_settings.svh"

module bus_control
    import z80_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  bus_req_t           bus_req,
    output logic               bus_done,
    output logic [`Z80_DW-1:0] rdata,
    output wb_m2s_t            wb_out,
    input  wb_s2m_t            wb_in
);

    typedef enum logic {BUS_IDLE, BUS_ACTIVE} bus_state_t;

    bus_state_t state;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= BUS_IDLE;
            bus_done <= 1'b0;
            wb_out   <= '0;
        end else begin
            bus_done <= 1'b0;
            case (state)
                BUS_IDLE: begin
                    // The old request is still up while bus_done is high
                    if (bus_req.valid && !bus_done) begin
                        wb_out.cyc <= 1'b1;
                        wb_out.stb <= 1'b1;
                        wb_out.we  <= bus_req.we;
                        wb_out.adr <= bus_req.adr;
                        wb_out.dat <= bus_req.wdata;
                        state      <= BUS_ACTIVE;
                    end
                end
                BUS_ACTIVE: begin
                    // Hold everything stable until the slave acks
                    if (wb_in.ack) begin
                        wb_out.cyc <= 1'b0;
                        wb_out.stb <= 1'b0;
                        wb_out.we  <= 1'b0;
                        bus_done   <= 1'b1;
                        state      <= BUS_IDLE;
                    end
                end
                default: state <= BUS_IDLE;
            endcase
        end
    end

    // Read data register, kept until the next read completes
    always_ff @(posedge clk) begin
        if (state == BUS_ACTIVE && wb_in.ack && !wb_out.we) begin
            rdata <= wb_in.dat;
        end
    end

endmodule

`default_nettype wire

// ==== hw/sequencer.sv ====
// Instruction register, opcode decode and the fetch/execute FSM
// Drives the bus requests and every datapath control of the core
`timescale 1ns/1ps
`default_nettype none

`include "z80_settings.svh"

module sequencer
    import z80_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    output bus_req_t           bus_req,
    input  logic               bus_done,
    input  logic [`Z80_DW-1:0] rdata,
    input  logic [`Z80_AW-1:0] pc,
    input  logic [`Z80_AW-1:0] oper_addr,
    output pc_op_t             pc_op,
    output logic               cap_lo,
    output logic               cap_hi,
    output logic [2:0]         rd_sel_a,
    output logic [2:0]         rd_sel_b,
    input  logic [`Z80_DW-1:0] rd_a,
    input  logic [`Z80_DW-1:0] rd_b,
    output logic               wr_en,
    output logic [2:0]         wr_sel,
    output logic [`Z80_DW-1:0] wr_data,
    output alu_op_t            alu_op,
    output logic [`Z80_DW-1:0] alu_a,
    output logic [`Z80_DW-1:0] alu_b,
    input  logic [`Z80_DW-1:0] alu_y,
    output logic               flag_we,
    input  flags_t             flags,
    output logic               halt
);

    localparam logic [2:0] REG_A  = 3'd7;
    localparam logic [2:0] REG_HL = 3'd6;

    cpu_state_t         state;
    cpu_state_t         state_nxt;
    logic [`Z80_DW-1:0] ir;

    // Opcode fields: group, destination or ALU op, source
    logic [1:0] grp;
    logic [2:0] fy;
    logic [2:0] fz;
    logic       is_ld_imm;
    logic       is_inc;
    logic       is_dec;
    logic       is_ld_rr;
    logic       is_alu;
    logic       is_ld_a_nn;
    logic       is_ld_nn_a;
    logic       is_jp;
    logic       jp_take;
    logic       is_halt;
    logic       needs_addr;

    assign grp = ir[7:6];
    assign fy  = ir[5:3];
    assign fz  = ir[2:0];

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Decode
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Register code 110 is (HL) and falls through as a NOP
    assign is_ld_imm  = (grp == 2'b00) && (fz == 3'b110) && (fy != REG_HL);
    assign is_inc     = (grp == 2'b00) && (fz == 3'b100) && (fy != REG_HL);
    assign is_dec     = (grp == 2'b00) && (fz == 3'b101) && (fy != REG_HL);
    assign is_ld_rr   = (grp == 2'b01) && (fy != REG_HL) && (fz != REG_HL);
    assign is_alu     = (grp == 2'b10) && (fz != REG_HL);
    assign is_ld_a_nn = (ir == OP_LD_A_NN);
    assign is_ld_nn_a = (ir == OP_LD_NN_A);
    assign is_halt    = (ir == OP_HALT);
    assign is_jp      = (ir == OP_JP_NN) || (ir == OP_JP_Z) || (ir == OP_JP_NZ);
    assign needs_addr = is_ld_a_nn || is_ld_nn_a || is_jp;

    // Condition from the stored Z flag
    assign jp_take = (ir == OP_JP_NN) ||
                     ((ir == OP_JP_Z) && flags.z) ||
                     ((ir == OP_JP_NZ) && !flags.z);

    // Every register write goes through the ALU
    assign wr_data = alu_y;

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // State, instruction register and halt
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_FETCH;
            ir    <= '0;
            halt  <= 1'b0;
        end else begin
            state <= state_nxt;
            // Opcode byte arrives with the fetch completion
            if (state == ST_FETCH && bus_done) begin
                ir <= rdata;
            end
            // Sticky until reset
            if (state == ST_DECODE && is_halt) begin
                halt <= 1'b1;
            end
        end
    end

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Next state and datapath controls
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        state_nxt = state;
        bus_req   = '0;
        pc_op     = PC_HOLD;
        cap_lo    = 1'b0;
        cap_hi    = 1'b0;
        rd_sel_a  = fz;
        rd_sel_b  = fz;
        wr_en     = 1'b0;
        wr_sel    = fy;
        alu_op    = ALU_PASS;
        alu_a     = rd_a;
        alu_b     = rd_b;
        flag_we   = 1'b0;

        case (state)
            ST_FETCH: begin
                bus_req.valid = 1'b1;
                bus_req.adr   = pc;
                if (bus_done) begin
                    pc_op     = PC_INC;
                    state_nxt = ST_DECODE;
                end
            end
            ST_DECODE: begin
                if (is_halt) begin
                    state_nxt = ST_HALTED;
                end else if (is_ld_imm || needs_addr) begin
                    state_nxt = ST_OPER_LO;
                end else if (is_inc || is_dec || is_ld_rr || is_alu) begin
                    state_nxt = ST_EXEC;
                end else begin
                    // Unsupported opcode behaves as a one-byte NOP
                    state_nxt = ST_FETCH;
                end
            end
            ST_OPER_LO: begin
                bus_req.valid = 1'b1;
                bus_req.adr   = pc;
                if (bus_done) begin
                    pc_op     = PC_INC;
                    cap_lo    = 1'b1;
                    state_nxt = needs_addr ? ST_OPER_HI : ST_EXEC;
                end
            end
            ST_OPER_HI: begin
                bus_req.valid = 1'b1;
                bus_req.adr   = pc;
                if (bus_done) begin
                    pc_op     = PC_INC;
                    cap_hi    = 1'b1;
                    state_nxt = is_jp ? ST_EXEC : ST_MEM;
                end
            end
            ST_MEM: begin
                // Store data always comes from A
                rd_sel_a      = REG_A;
                bus_req.valid = 1'b1;
                bus_req.we    = is_ld_nn_a;
                bus_req.adr   = oper_addr;
                bus_req.wdata = rd_a;
                if (bus_done) begin
                    state_nxt = is_ld_a_nn ? ST_EXEC : ST_FETCH;
                end
            end
            ST_EXEC: begin
                state_nxt = ST_FETCH;
                if (is_alu) begin
                    // CP only updates the flags
                    rd_sel_a = REG_A;
                    alu_op   = alu_op_t'({1'b0, fy});
                    flag_we  = 1'b1;
                    wr_en    = (fy != 3'b111);
                    wr_sel   = REG_A;
                end else if (is_inc || is_dec) begin
                    rd_sel_a = fy;
                    alu_op   = is_inc ? ALU_INC : ALU_DEC;
                    flag_we  = 1'b1;
                    wr_en    = 1'b1;
                end else if (is_ld_rr) begin
                    wr_en = 1'b1;
                end else if (is_ld_imm) begin
                    // Immediate byte still held by the bus controller
                    alu_a = rdata;
                    wr_en = 1'b1;
                end else if (is_ld_a_nn) begin
                    alu_a  = rdata;
                    wr_en  = 1'b1;
                    wr_sel = REG_A;
                end else if (is_jp && jp_take) begin
                    pc_op = PC_LOAD;
                end
            end
            ST_HALTED: begin
                state_nxt = ST_HALTED;
            end
            default: begin
                state_nxt = ST_FETCH;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/z80_top.sv ====
// Core top level with a single Wishbone classic master port
// Wires the sequencer, ALU, register file, address latch and bus controller
`timescale 1ns/1ps
`default_nettype none

`include "z80_settings.svh"

module z80_top
    import z80_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    output wb_m2s_t wb_out,
    input  wb_s2m_t wb_in,
    output logic    halt
);

// Sequencer to bus controller handshake
bus_req_t           bus_req;
logic               bus_done;
logic [`Z80_DW-1:0] rdata;

// Program counter and operand address
logic [`Z80_AW-1:0] pc;
logic [`Z80_AW-1:0] oper_addr;
pc_op_t             pc_op;
logic               cap_lo;
logic               cap_hi;

// Register file ports
logic [2:0]         rd_sel_a;
logic [2:0]         rd_sel_b;
logic [`Z80_DW-1:0] rd_a;
logic [`Z80_DW-1:0] rd_b;
logic               wr_en;
logic [2:0]         wr_sel;
logic [`Z80_DW-1:0] wr_data;

// ALU control and result
alu_op_t            alu_op;
logic [`Z80_DW-1:0] alu_a;
logic [`Z80_DW-1:0] alu_b;
logic [`Z80_DW-1:0] alu_y;
logic               flag_we;
flags_t             flags;

//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Control block
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
sequencer sequencer ( .* );

//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ALU with its flag register
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
alu alu ( .* );

//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register file
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
reg_file reg_file ( .* );

//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Address latch with the PC incrementer
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
address_latch address_latch ( .* );

//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory side bus master
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
bus_control bus_control ( .* );

endmodule

`default_nettype wire

// ==== verification/z80_assertions.sv ====
// Concurrent checks on the core's Wishbone master port and halt output
// Bound into every z80_top instance
`timescale 1ns/1ps
`default_nettype none

module z80_assertions
    import z80_pkg::*;
(
    input logic    clk,
    input logic    rst_n,
    input wb_m2s_t wb_out,
    input wb_s2m_t wb_in,
    input logic    halt
);

    // Strobe only inside a cycle
    stb_in_cyc: assert property (@(posedge clk) disable iff (!rst_n)
        wb_out.stb |-> wb_out.cyc)
        else $error("Wishbone stb high without cyc");

    // Master holds the transfer until it is acked
    req_held: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_out.stb && !wb_in.ack) |=>
            (wb_out.stb && $stable(wb_out.adr) && $stable(wb_out.we) && $stable(wb_out.dat)))
        else $error("Wishbone request changed before ack");

    // Sticky until reset
    halt_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        halt |=> halt)
        else $error("halt fell without reset");

endmodule

bind z80_top z80_assertions wb_checks (
    .clk    (clk),
    .rst_n  (rst_n),
    .wb_out (wb_out),
    .wb_in  (wb_in),
    .halt   (halt)
);

`default_nettype wire

// ==== verification/z80_tb.sv ====
// Testbench for the cut-down Z80 core on a Wishbone memory model with random wait states
// Loads program and expected bytes from the pattern file, runs to HALT, then checks memory
`timescale 1ns/1ps
`default_nettype none

`include "z80_settings.svh"

module z80_tb
    import z80_pkg::*;
();

    localparam int REC_MAX = 256;

    logic    clk = 1'b0;
    logic    rst_n = 1'b0;
    wb_m2s_t wb_out;
    wb_s2m_t wb_in = '0;
    logic    halt;

    // Memory image, raw records and the expected bytes after HALT
    logic [7:0]  mem [0:65535];
    logic [27:0] recs [0:REC_MAX-1];
    logic [15:0] exp_addr [$];
    logic [7:0]  exp_data [$];

    integer seed = 12057;
    integer wait_left = -1;
    integer cyc_starts = 0;
    logic   cyc_seen = 1'b0;
    integer cycle_count = 0;
    integer limit = 32'h7fff_ffff;
    integer idle_cycles;
    integer starts_at_halt;

    z80_top uut (
        .clk    (clk),
        .rst_n  (rst_n),
        .wb_out (wb_out),
        .wb_in  (wb_in),
        .halt   (halt)
    );

    // 40 ns period
    always #20 clk = ~clk;

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("Error at %0d ns: %s is %0h, expected %0h", $time, what, actual, expected);
            $display("*** TEST FAILED ***");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    // Records are type, address and byte packed into one 28-bit word
    task automatic load_patterns();
        logic [3:0]  kind;
        logic [15:0] addr;
        logic [7:0]  data;
        integer      prog_bytes;
        prog_bytes = 0;
        for (int a = 0; a < 65536; a++) begin
            mem[16'(a)] = 8'h00;
        end
        // Unused entries read back as type F and end the list
        for (int i = 0; i < REC_MAX; i++) begin
            recs[8'(i)] = '1;
        end
        $readmemh("verification/z80_patterns.mem", recs);
        for (int i = 0; i < REC_MAX; i++) begin
            {kind, addr, data} = recs[8'(i)];
            if (kind == 4'hF) begin
                break;
            end
            if (kind == 4'h0) begin
                mem[addr]  = data;
                prog_bytes = prog_bytes + 1;
            end else if (kind == 4'h1) begin
                exp_addr.push_back(addr);
                exp_data.push_back(data);
            end else begin
                $display("Pattern file entry %0d has an unknown record type %0h", i, kind);
                $display("*** TEST FAILED ***");
                $fatal(1, "Bad pattern file");
            end
        end
        if (prog_bytes == 0 || exp_addr.size() == 0) begin
            $display("Pattern file holds no program bytes or no expected memory bytes");
            $display("*** TEST FAILED ***");
            $fatal(1, "Bad pattern file");
        end
        // Worst case of four transfers of five cycles per byte
        limit = prog_bytes * 4 * 5 + 100;
    endtask

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Wishbone slave, driven on the falling edge
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        load_patterns();
        forever begin
            @(negedge clk);
            if (!rst_n) begin
                wb_in     = '0;
                wait_left = -1;
                cyc_seen  = 1'b0;
            end else begin
                // Count every new bus cycle for the check after HALT
                if (wb_out.cyc && !cyc_seen) begin
                    cyc_starts = cyc_starts + 1;
                end
                cyc_seen = wb_out.cyc;
                if (wb_in.ack) begin
                    // Master took the ack at the last rising edge
                    wb_in.ack = 1'b0;
                    wait_left = -1;
                end else if (wb_out.cyc && wb_out.stb) begin
                    if (wait_left < 0) begin
                        wait_left = $unsigned($random(seed)) % 4;
                    end
                    if (wait_left == 0) begin
                        wb_in.ack = 1'b1;
                        if (wb_out.we) begin
                            mem[wb_out.adr] = wb_out.dat;
                        end else begin
                            wb_in.dat = mem[wb_out.adr];
                        end
                    end else begin
                        wait_left = wait_left - 1;
                    end
                end
            end
        end
    end

    // Run limit
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= limit) begin
            $display("Timeout: HALT never came within %0d cycles", limit);
            $display("*** TEST FAILED ***");
            $fatal(1, "Simulation stopped by timeout");
        end
    end

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reset, run to HALT and compare memory
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        @(negedge clk);
        check_value(32'(wb_out.cyc), 0, "cyc in reset");
        check_value(32'(wb_out.stb), 0, "stb in reset");
        check_value(32'(wb_out.we), 0, "we in reset");
        check_value(32'(halt), 0, "halt in reset");
        @(negedge clk);
        rst_n = 1'b1;

        // First opcode fetch within two cycles
        idle_cycles = 0;
        while (!wb_out.cyc && idle_cycles < 2) begin
            @(negedge clk);
            idle_cycles = idle_cycles + 1;
        end
        check_value(32'(wb_out.cyc), 1, "first fetch started");
        check_value(32'(wb_out.adr), 32'(`Z80_RESET_PC), "first fetch address");
        check_value(32'(wb_out.we), 0, "first fetch direction");

        while (!halt) begin
            @(negedge clk);
        end
        check_value(32'(wb_out.cyc), 0, "cyc when halt rises");
        @(posedge clk);
        starts_at_halt = cyc_starts;

        // Halted core stays quiet and halt holds
        repeat (20) begin
            @(negedge clk);
            check_value(32'(halt), 1, "halt after HALT");
        end
        @(posedge clk);
        check_value(cyc_starts, starts_at_halt, "bus cycles started after HALT");

        for (int i = 0; i < exp_addr.size(); i++) begin
            check_value(32'(mem[exp_addr[i]]), 32'(exp_data[i]),
                        $sformatf("memory byte at %04h", exp_addr[i]));
        end

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/z80_patterns.mem ====
// Each word is type_address_byte: type 0 is a program or data byte,
// type 1 is the byte expected in memory after HALT
// Registers through LD r,n and LD r,r', stored with LD (nn),A
0_0000_06 0_0001_11 0_0002_0E 0_0003_22 0_0004_16 0_0005_33 0_0006_1E 0_0007_44
0_0008_26 0_0009_55 0_000A_2E 0_000B_66 0_000C_3E 0_000D_77 0_000E_32 0_000F_00
0_0010_01 0_0011_78 0_0012_32 0_0013_01 0_0014_01 0_0015_79 0_0016_32 0_0017_02
0_0018_01 0_0019_7A 0_001A_32 0_001B_03 0_001C_01 0_001D_7B 0_001E_32 0_001F_04
0_0020_01 0_0021_7C 0_0022_32 0_0023_05 0_0024_01 0_0025_7D 0_0026_32 0_0027_06
0_0028_01 0_0029_62 0_002A_7C 0_002B_32 0_002C_07 0_002D_01 0_002E_3E 0_002F_90
// ALU chain on A with B = 80 and C = 20, then INC A and DEC B
0_0030_06 0_0031_80 0_0032_0E 0_0033_20 0_0034_80 0_0035_32 0_0036_08 0_0037_01
0_0038_88 0_0039_32 0_003A_09 0_003B_01 0_003C_91 0_003D_32 0_003E_0A 0_003F_01
0_0040_90 0_0041_32 0_0042_0B 0_0043_01 0_0044_99 0_0045_32 0_0046_0C 0_0047_01
0_0048_A0 0_0049_32 0_004A_0D 0_004B_01 0_004C_B1 0_004D_32 0_004E_0E 0_004F_01
0_0050_A8 0_0051_32 0_0052_0F 0_0053_01 0_0054_B8 0_0055_32 0_0056_10 0_0057_01
0_0058_3C 0_0059_32 0_005A_11 0_005B_01 0_005C_05 0_005D_78 0_005E_32 0_005F_12
// Conditional and plain jumps with markers, trap block at 0092
0_0060_01 0_0061_BF 0_0062_C2 0_0063_92 0_0064_00 0_0065_3E 0_0066_A1 0_0067_32
0_0068_20 0_0069_01 0_006A_CA 0_006B_72 0_006C_00 0_006D_3E 0_006E_E1 0_006F_32
0_0070_21 0_0071_01 0_0072_B8 0_0073_CA 0_0074_92 0_0075_00 0_0076_3E 0_0077_A2
0_0078_32 0_0079_22 0_007A_01 0_007B_C2 0_007C_83 0_007D_00 0_007E_3E 0_007F_E2
0_0080_32 0_0081_23 0_0082_01 0_0083_C3 0_0084_8B 0_0085_00 0_0086_3E 0_0087_E3
0_0088_32 0_0089_24 0_008A_01 0_008B_3A 0_008C_00 0_008D_02 0_008E_32 0_008F_25
0_0090_01 0_0091_76 0_0092_3E 0_0093_EE 0_0094_32 0_0095_2F 0_0096_01 0_0097_76
// Data byte for LD A,(0200)
0_0200_5A
// Expected results
1_0100_77 1_0101_11 1_0102_22 1_0103_33 1_0104_44 1_0105_55 1_0106_66 1_0107_33
1_0108_10 1_0109_91 1_010A_71 1_010B_F1 1_010C_D0 1_010D_80 1_010E_A0 1_010F_20
1_0110_20 1_0111_21 1_0112_7F 1_0120_A1 1_0121_00 1_0122_A2 1_0123_00 1_0124_00
1_0125_5A 1_012F_00

// ==== sim.f ====
+incdir+hw
hw/z80_pkg.sv
hw/reg_file.sv
hw/alu.sv
hw/address_latch.sv
hw/bus_control.sv
hw/sequencer.sv
hw/z80_top.sv
verification/z80_assertions.sv
verification/z80_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the Z80 core and its testbench with Verilator, runs it, and
# succeeds only when the simulation output holds the pass message.
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module z80_tb \
    -Mdir obj_dir -o z80_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/z80_sim 2>&1)
status=$?
printf '%s\n' "$output"

if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qF '*** TEST PASSED ***'; then
    exit 0
fi

echo "Simulation output has no pass message"
exit 1
